// ==== sources.f ====
+incdir+logic
logic/xm_pkg.sv
logic/reg_wr_if.sv
logic/vram_regs_if.sv
logic/reg_write_merge.sv
logic/vram_port.sv
logic/sys_regs.sv
logic/reg_read_mux.sv
logic/xm_regs.sv
verification/xm_regs_checker.sv
verification/xm_regs_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vxm_regs_tb

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

$(SIM): sources.f $(wildcard logic/*.sv logic/*.svh verification/*.sv)
	verilator --binary --timing -f sources.f --top-module xm_regs_tb -o Vxm_regs_tb

clean:
	rm -rf obj_dir

// ==== verification/xm_regs_tb.sv ====
// Testbench for the host register file.
// Clock, reset, VRAM model with random video stalls, and a stimulus table
// applied in a loop; xm_regs_checker does the comparing.
`default_nettype none
`timescale 1ns/1ps

module xm_regs_tb;

    localparam logic [2:0] OP_WW   = 3'd0;  // even then odd write
    localparam logic [2:0] OP_W    = 3'd1;  // single byte write
    localparam logic [2:0] OP_RW   = 3'd2;  // read both bytes, check word
    localparam logic [2:0] OP_EXP  = 3'd3;  // queue expected vram write
    localparam logic [2:0] OP_IDLE = 3'd4;  // wait for vram_sel_o low
    localparam logic [2:0] OP_MASK = 3'd5;  // check vram_wrmask_o
    localparam logic [2:0] OP_TMR  = 3'd6;  // timer rate

    typedef struct packed {
        logic [2:0]     op;
        logic [2:0]     grp;                // test number
        logic [3:0]     rn;
        logic           bs;
        logic [15:0]    d;                  // write data or vram address
        logic [15:0]    x;                  // expected word
    } entry_t;

    logic           clk = 1'b0;
    logic           reset_i, bus_wr_i, bus_rd_i, bus_bytesel_i;
    logic [3:0]     bus_reg_num_i, vram_wrmask_o;
    logic [7:0]     bus_data_i, bus_data_o;
    logic           vram_sel_o, vram_wr_o;
    logic [15:0]    vram_addr_o, vram_data_o;
    logic [15:0]    vram_data_i = '0;
    logic           vgen_sel_i = 1'b0;
    logic [15:0]    mem [0:65535];          // vram model
    entry_t         tbl[$];
    integer         seed = 57;
    integer         rnd;
    int             grp_err;
    logic [15:0]    t0, t1;

    xm_regs u_dut (.*);

    xm_regs_checker u_chk (
        .clk(clk), .bus_data_i(bus_data_o), .vram_sel_i(vram_sel_o), .vram_wr_i(vram_wr_o),
        .vgen_sel_i(vgen_sel_i), .vram_addr_i(vram_addr_o), .vram_data_i(vram_data_o),
        .wrmask_i(vram_wrmask_o)
    );

    initial begin
        forever #4 clk = ~clk;              // 8 ns period
    end

    // vram model with nibble masked writes and next-cycle read data
    always @(posedge clk) begin
        rnd = $random(seed);
        vgen_sel_i <= rnd[0];
        if (reset_i) begin
            for (int a = 0; a < 65536; a++) mem[a] = ~16'(a);
        end else if (vram_sel_o && !vgen_sel_i) begin
            if (vram_wr_o) begin
                for (int i = 0; i < 4; i++)
                    if (vram_wrmask_o[i]) mem[vram_addr_o][4*i +: 4] = vram_data_o[4*i +: 4];
            end else begin
                vram_data_i <= mem[vram_addr_o];
            end
        end
    end

    task automatic add(input logic [2:0] op, input logic [2:0] grp, input logic [3:0] rn,
                       input logic bs, input logic [15:0] d, input logic [15:0] x);
        tbl.push_back({op, grp, rn, bs, d, x});
    endtask

    task automatic host_write(input logic [3:0] rn, input logic bs, input logic [7:0] d);
        @(posedge clk);
        bus_wr_i <= 1'b1;
        bus_reg_num_i <= rn;
        bus_bytesel_i <= bs;
        bus_data_i <= d;
        @(posedge clk);
        bus_wr_i <= 1'b0;
    endtask

    task automatic host_read(input logic [3:0] rn, input logic bs, output logic [7:0] b);
        @(posedge clk);
        bus_rd_i <= 1'b1;
        bus_reg_num_i <= rn;
        bus_bytesel_i <= bs;
        @(negedge clk);                     // mux output settled
        b = bus_data_o;
        @(posedge clk);
        bus_rd_i <= 1'b0;
    endtask

    task automatic read_check(input logic [3:0] rn, input logic bs, input logic [7:0] exp);
        @(posedge clk);
        bus_rd_i <= 1'b1;
        bus_reg_num_i <= rn;
        bus_bytesel_i <= bs;
        @(negedge clk);
        u_chk.check_read(rn, bs, exp);
        @(posedge clk);
        bus_rd_i <= 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        repeat (3) @(posedge clk);          // request starts two cycles after host
        while (vram_sel_o && n < 200) begin
            @(posedge clk);
            n++;
        end
        if (n >= 200) begin
            $display("timeout: vram_sel_o stayed high for 200 cycles");
            $display("TEST FAILED");
            $finish;
        end else begin
            repeat (2) @(posedge clk);      // read data latch
        end
    endtask

    initial begin
        {reset_i, bus_wr_i, bus_rd_i, bus_bytesel_i} = 4'b1000;
        bus_reg_num_i = '0;
        bus_data_i = '0;
        // reset values
        add(OP_RW, 1, xm_pkg::RD_INCR, 0, 0, 16'h0000);
        add(OP_RW, 1, xm_pkg::RD_ADDR, 0, 0, 16'h0000);
        add(OP_RW, 1, xm_pkg::WR_INCR, 0, 0, 16'h0000);
        add(OP_RW, 1, xm_pkg::WR_ADDR, 0, 0, 16'h0000);
        add(OP_RW, 1, xm_pkg::DATA, 0, 0, 16'h0000);
        add(OP_RW, 1, xm_pkg::SYS_CTRL, 0, 0, 16'h000F);
        add(OP_RW, 1, xm_pkg::TIMER, 0, 0, 16'h0000);
        // register readback and odd-only write after a foreign even byte
        add(OP_W, 2, xm_pkg::RD_ADDR, 0, 16'h0077, 0);
        add(OP_W, 2, xm_pkg::RD_INCR, 1, 16'h0002, 0);
        add(OP_RW, 2, xm_pkg::RD_INCR, 0, 0, 16'h0002);
        add(OP_RW, 2, xm_pkg::RD_ADDR, 0, 0, 16'h7700);
        add(OP_WW, 2, xm_pkg::WR_INCR, 0, 16'h0010, 0);
        add(OP_RW, 2, xm_pkg::WR_INCR, 0, 0, 16'h0010);
        // data port writes step by wr_incr
        add(OP_WW, 3, xm_pkg::WR_ADDR, 0, 16'h1234, 0);
        add(OP_EXP, 3, 0, 0, 16'h1234, 16'hABCD);
        add(OP_WW, 3, xm_pkg::DATA, 0, 16'hABCD, 0);
        add(OP_IDLE, 3, 0, 0, 0, 0);
        add(OP_EXP, 3, 0, 0, 16'h1244, 16'h1122);
        add(OP_WW, 3, xm_pkg::DATA, 0, 16'h1122, 0);
        add(OP_IDLE, 3, 0, 0, 0, 0);
        add(OP_EXP, 3, 0, 0, 16'h1254, 16'h5566);
        add(OP_WW, 3, xm_pkg::DATA_2, 0, 16'h5566, 0);
        add(OP_IDLE, 3, 0, 0, 0, 0);
        add(OP_RW, 3, xm_pkg::WR_ADDR, 0, 0, 16'h1264);
        // reads with prefetch against a model that holds ~addr
        add(OP_WW, 4, xm_pkg::RD_ADDR, 0, 16'h0100, 0);
        add(OP_IDLE, 4, 0, 0, 0, 0);
        add(OP_RW, 4, xm_pkg::DATA, 0, 0, 16'hFEFF);
        add(OP_IDLE, 4, 0, 0, 0, 0);
        add(OP_RW, 4, xm_pkg::DATA_2, 0, 0, 16'hFEFD);
        add(OP_IDLE, 4, 0, 0, 0, 0);
        add(OP_RW, 4, xm_pkg::RD_ADDR, 0, 0, 16'h0106);
        // write mask 0101 keeps nibbles 3 and 1 of 0xFDFF
        add(OP_WW, 5, xm_pkg::SYS_CTRL, 0, 16'h0005, 0);
        add(OP_MASK, 5, 0, 0, 0, 16'h0005);
        add(OP_RW, 5, xm_pkg::SYS_CTRL, 0, 0, 16'h0005);
        add(OP_WW, 5, xm_pkg::WR_ADDR, 0, 16'h0200, 0);
        add(OP_EXP, 5, 0, 0, 16'h0200, 16'h1234);
        add(OP_WW, 5, xm_pkg::DATA, 0, 16'h1234, 0);
        add(OP_IDLE, 5, 0, 0, 0, 0);
        add(OP_WW, 5, xm_pkg::RD_ADDR, 0, 16'h0200, 0);
        add(OP_IDLE, 5, 0, 0, 0, 0);
        add(OP_RW, 5, xm_pkg::DATA, 0, 0, 16'hF2F4);
        add(OP_IDLE, 5, 0, 0, 0, 0);
        add(OP_TMR, 6, xm_pkg::TIMER, 0, 0, 0);

        repeat (5) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        u_chk.expect_sel_low();             // no request out of reset
        grp_err = 0;
        foreach (tbl[i]) begin
            case (tbl[i].op)
                OP_WW: begin
                    host_write(tbl[i].rn, 1'b0, tbl[i].d[15:8]);
                    host_write(tbl[i].rn, 1'b1, tbl[i].d[7:0]);
                end
                OP_W:    host_write(tbl[i].rn, tbl[i].bs, tbl[i].d[7:0]);
                OP_RW: begin
                    read_check(tbl[i].rn, 1'b0, tbl[i].x[15:8]);
                    read_check(tbl[i].rn, 1'b1, tbl[i].x[7:0]);
                end
                OP_EXP:  u_chk.expect_write(tbl[i].d, tbl[i].x);
                OP_IDLE: wait_idle();
                OP_MASK: begin
                    repeat (2) @(negedge clk);  // merge stage then mask register
                    u_chk.check_mask(tbl[i].x[3:0]);
                end
                default: begin
                    host_read(tbl[i].rn, 1'b0, t0[15:8]);
                    host_read(tbl[i].rn, 1'b1, t0[7:0]);
                    repeat (25000) @(posedge clk);
                    host_read(tbl[i].rn, 1'b0, t1[15:8]);
                    host_read(tbl[i].rn, 1'b1, t1[7:0]);
                    u_chk.check_timer(t0, t1);
                end
            endcase
            if (i == tbl.size() - 1 || tbl[i+1].grp != tbl[i].grp) begin
                $display("test %0d done, %0d errors", tbl[i].grp, u_chk.err_cnt - grp_err);
                grp_err = u_chk.err_cnt;
            end
        end
        u_chk.check_drained();
        $display("checks %0d, errors %0d", u_chk.chk_cnt, u_chk.err_cnt);
        if (u_chk.err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/xm_regs_checker.sv ====
// Testbench checker for the host register file.
// Compares host readback against expected bytes and VRAM write events against
// a queue of expected writes; keeps the check and error counts.
`default_nettype none
`timescale 1ns/1ps

module xm_regs_checker (
    input  wire logic           clk,
    input  wire logic [7:0]     bus_data_i,     // dut host read bus
    input  wire logic           vram_sel_i,
    input  wire logic           vram_wr_i,
    input  wire logic           vgen_sel_i,
    input  wire logic [15:0]    vram_addr_i,
    input  wire logic [15:0]    vram_data_i,    // dut write word
    input  wire logic [3:0]     wrmask_i
);

    int             chk_cnt = 0;
    int             err_cnt = 0;
    logic [31:0]    exp_wr[$];                  // {addr, data} in issue order

    task automatic check_read(input logic [3:0] rn, input logic bs, input logic [7:0] exp);
        chk_cnt++;
        if (bus_data_i !== exp) begin
            err_cnt++;
            $display("ERR bus_data_o reg %h byte %0d: got %h exp %h", rn, bs, bus_data_i, exp);
        end
    endtask

    task automatic check_mask(input logic [3:0] exp);
        chk_cnt++;
        if (wrmask_i !== exp) begin
            err_cnt++;
            $display("ERR vram_wrmask_o: got %h exp %h", wrmask_i, exp);
        end
    endtask

    task automatic expect_sel_low();
        chk_cnt++;
        if (vram_sel_i !== 1'b0) begin
            err_cnt++;
            $display("ERR vram_sel_o: got %h exp 0", vram_sel_i);
        end
    endtask

    task automatic expect_write(input logic [15:0] addr, input logic [15:0] data);
        exp_wr.push_back({addr, data});
    endtask

    task automatic check_timer(input logic [15:0] t0, input logic [15:0] t1);
        logic [15:0] diff;
        diff = t1 - t0;                         // wrap safe
        chk_cnt++;
        if (diff < 16'd9 || diff > 16'd11) begin
            err_cnt++;
            $display("timer moved by %0d ticks over 25000 cycles, expected 9 to 11", diff);
        end
    endtask

    task automatic check_drained();
        if (exp_wr.size() != 0) begin
            err_cnt++;
            $display("%0d expected VRAM writes never happened", exp_wr.size());
        end
    endtask

    // a write completes in the first free slot
    always @(posedge clk) begin
        logic [31:0] e;
        if (vram_sel_i && vram_wr_i && !vgen_sel_i) begin
            if (exp_wr.size() == 0) begin
                err_cnt++;
                $display("unexpected VRAM write at address %h", vram_addr_i);
            end else begin
                e = exp_wr.pop_front();
                chk_cnt++;
                if (vram_addr_i !== e[31:16] || vram_data_i !== e[15:0]) begin
                    err_cnt++;
                    $display("ERR vram_addr_o/vram_data_o: got %h/%h exp %h/%h",
                             vram_addr_i, vram_data_i, e[31:16], e[15:0]);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/xm_regs.sv ====
// Host register file top level.
// Host strobe bus in, shared VRAM request port out; all ports are plain.
`default_nettype none
`timescale 1ns/1ps

`include "xm_defs.svh"

module xm_regs (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   bus_wr_i,       // host write strobe
    input  wire logic                   bus_rd_i,       // host read strobe
    input  wire logic [3:0]             bus_reg_num_i,
    input  wire logic                   bus_bytesel_i,  // 0 even/high, 1 odd/low
    input  wire logic [`XM_BYTE_W-1:0]  bus_data_i,
    output      logic [`XM_BYTE_W-1:0]  bus_data_o,     // combinational readback
    output      logic                   vram_sel_o,
    output      logic                   vram_wr_o,
    output      logic [`XM_WORD_W-1:0]  vram_addr_o,
    output      logic [`XM_WORD_W-1:0]  vram_data_o,
    output      logic [3:0]             vram_wrmask_o,  // nibble enables
    input  wire logic [`XM_WORD_W-1:0]  vram_data_i,
    input  wire logic                   vgen_sel_i      // video slot busy
);

    logic [3:0]             wrmask;     // from sys_regs
    logic [`XM_WORD_W-1:0]  timer;      // from sys_regs

    reg_wr_if       u_wr_if ();         // merged host events
    vram_regs_if    u_vregs_if ();      // vram port readback

    reg_write_merge u_merge (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_wr_i       (bus_wr_i),
        .bus_rd_i       (bus_rd_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_data_i     (bus_data_i),
        .wr             (u_wr_if.source)
    );

    vram_port u_vram_port (
        .clk            (clk),
        .reset_i        (reset_i),
        .wr             (u_wr_if.sink),
        .regs           (u_vregs_if.source),
        .vram_data_i    (vram_data_i),
        .vgen_sel_i     (vgen_sel_i),
        .vram_sel_o     (vram_sel_o),
        .vram_wr_o      (vram_wr_o),
        .vram_addr_o    (vram_addr_o),
        .vram_data_o    (vram_data_o)
    );

    sys_regs u_sys_regs (
        .clk            (clk),
        .reset_i        (reset_i),
        .wr             (u_wr_if.sink),
        .wrmask_o       (wrmask),
        .timer_o        (timer)
    );

    reg_read_mux u_read_mux (
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .regs           (u_vregs_if.sink),
        .wrmask_i       (wrmask),
        .timer_i        (timer),
        .bus_data_o     (bus_data_o)
    );

    assign vram_wrmask_o = wrmask;      // mask applies to every vram write

endmodule

`default_nettype wire

// ==== logic/reg_read_mux.sv ====
// Host read data select.
// Purely combinational: follows register number and byte select directly.
`default_nettype none
`timescale 1ns/1ps

`include "xm_defs.svh"

module reg_read_mux (
    input  wire logic [3:0]             bus_reg_num_i,  // register number
    input  wire logic                   bus_bytesel_i,  // 0 high byte, 1 low byte
    vram_regs_if.sink                   regs,           // vram port values
    input  wire logic [3:0]             wrmask_i,       // current write mask
    input  wire logic [`XM_WORD_W-1:0]  timer_i,        // 1/10 ms count
    output      logic [`XM_BYTE_W-1:0]  bus_data_o
);

    localparam int HI = `XM_WORD_W - 1;
    localparam int LO = `XM_BYTE_W;

    logic [HI:0]    sel_word;       // addressed register as a word

    always_comb begin
        case (xm_pkg::xm_reg_e'(bus_reg_num_i))
            xm_pkg::RD_INCR:  sel_word = regs.rd_incr;
            xm_pkg::RD_ADDR:  sel_word = regs.rd_addr;
            xm_pkg::WR_INCR:  sel_word = regs.wr_incr;
            xm_pkg::WR_ADDR:  sel_word = regs.wr_addr;
            xm_pkg::DATA,
            xm_pkg::DATA_2:   sel_word = regs.rd_data;  // both aliases
            xm_pkg::SYS_CTRL: sel_word = {{(`XM_WORD_W-4){1'b0}}, wrmask_i};
            xm_pkg::TIMER:    sel_word = timer_i;
            default:          sel_word = '0;            // 8..15 read zero
        endcase
        bus_data_o = bus_bytesel_i ? sel_word[LO-1:0] : sel_word[HI:LO];
    end

endmodule

`default_nettype wire

// ==== logic/sys_regs.sv ====
// System control: VRAM nibble write mask and the 1/10 ms timer.
// Mask loads from the odd byte of a SYS_CTRL write; the timer free-runs.
`default_nettype none
`timescale 1ns/1ps

`include "xm_defs.svh"

module sys_regs (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    reg_wr_if.sink                      wr,         // host register events
    output      logic [3:0]             wrmask_o,   // vram nibble enables
    output      logic [`XM_WORD_W-1:0]  timer_o     // 1/10 ms count
);

    localparam int FRAC_W = $clog2(`XM_TIMER_DIV);

    logic [FRAC_W-1:0]      frac;       // clocks within current tick
    logic                   tick;       // last clock of a tick

    assign tick = (frac == FRAC_W'(`XM_TIMER_DIV - 1));

    // write mask
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wrmask_o <= `XM_WRMASK_RESET;
        end else if (wr.word_wr && (wr.reg_num == xm_pkg::SYS_CTRL)) begin
            wrmask_o <= wr.word_data[3:0];  // low nibble of odd byte
        end
    end

    // fractional divider then visible count
    always_ff @(posedge clk) begin
        if (reset_i) begin
            frac    <= '0;
            timer_o <= '0;
        end else if (tick) begin
            frac    <= '0;
            timer_o <= timer_o + 1'b1;      // wraps at 16 bits
        end else begin
            frac    <= frac + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/vram_port.sv ====
// VRAM address/increment registers and the shared VRAM request port.
// One access at a time; a request holds vram_sel_o until the video
// generator leaves a free slot (vgen_sel_i low), read data is latched next cycle.
`default_nettype none
`timescale 1ns/1ps

`include "xm_defs.svh"

module vram_port (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    reg_wr_if.sink                      wr,             // host register events
    vram_regs_if.source                 regs,           // values for readback
    input  wire logic [`XM_WORD_W-1:0]  vram_data_i,    // read data, cycle after done
    input  wire logic                   vgen_sel_i,     // video owns vram this cycle
    output      logic                   vram_sel_o,     // request active
    output      logic                   vram_wr_o,      // 1 write, 0 read
    output      logic [`XM_WORD_W-1:0]  vram_addr_o,
    output      logic [`XM_WORD_W-1:0]  vram_data_o
);

    localparam int HI = `XM_WORD_W - 1;     // top bit of a word
    localparam int LO = `XM_BYTE_W;         // first bit of high byte

    xm_pkg::vram_state_e    state;
    logic [HI:0]            rd_incr;
    logic [HI:0]            rd_addr;
    logic [HI:0]            wr_incr;
    logic [HI:0]            wr_addr;
    logic [HI:0]            rd_data;        // latched read word
    logic                   is_data;        // DATA or DATA_2 addressed
    logic                   start_rd_new;   // read at freshly written address
    logic                   start_rd_next;  // prefetch after odd data read
    logic                   start_wr;       // data port write
    logic                   start_any;      // launch a request this cycle
    logic [HI:0]            req_addr;       // address for new request

    always_comb begin
        is_data       = (wr.reg_num == xm_pkg::DATA) || (wr.reg_num == xm_pkg::DATA_2);
        start_rd_new  = wr.word_wr && (wr.reg_num == xm_pkg::RD_ADDR);
        start_rd_next = wr.odd_rd && is_data;
        start_wr      = wr.word_wr && is_data;
        start_any     = (state != xm_pkg::VP_REQ)
                      && (start_rd_new || start_rd_next || start_wr);
        if (start_wr) begin
            req_addr = wr_addr;
        end else if (start_rd_new) begin
            req_addr = {rd_addr[HI:LO], wr.word_data[LO-1:0]};  // new low byte
        end else begin
            req_addr = rd_addr;                                 // prefetch
        end
    end

    // sequencer and registers
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state       <= xm_pkg::VP_IDLE;
            vram_sel_o  <= 1'b0;
            vram_wr_o   <= 1'b0;
            rd_incr     <= '0;
            rd_addr     <= '0;
            wr_incr     <= '0;
            wr_addr     <= '0;
            rd_data     <= '0;              // DATA reads zero after reset
        end else begin
            case (state)
                xm_pkg::VP_REQ: begin
                    if (!vgen_sel_i) begin  // free slot, access happens now
                        vram_sel_o  <= 1'b0;
                        vram_wr_o   <= 1'b0;
                        if (vram_wr_o) begin
                            wr_addr <= wr_addr + wr_incr;
                            state   <= xm_pkg::VP_IDLE;
                        end else begin
                            rd_addr <= rd_addr + rd_incr;
                            state   <= xm_pkg::VP_ACK;
                        end
                    end
                end
                xm_pkg::VP_ACK: begin
                    rd_data <= vram_data_i; // word valid now
                    state   <= xm_pkg::VP_IDLE;
                end
                default: ;
            endcase

            // even byte only touches address high bytes
            if (wr.even_wr) begin
                case (wr.reg_num)
                    xm_pkg::RD_ADDR: rd_addr[HI:LO] <= wr.byte_data;
                    xm_pkg::WR_ADDR: wr_addr[HI:LO] <= wr.byte_data;
                    default: ;
                endcase
            end

            if (wr.word_wr) begin
                case (wr.reg_num)
                    xm_pkg::RD_INCR: rd_incr          <= wr.word_data;
                    xm_pkg::RD_ADDR: rd_addr[LO-1:0]  <= wr.word_data[LO-1:0];
                    xm_pkg::WR_INCR: wr_incr          <= wr.word_data;
                    xm_pkg::WR_ADDR: wr_addr[LO-1:0]  <= wr.word_data[LO-1:0];
                    default: ;
                endcase
            end

            if (start_any) begin
                state       <= xm_pkg::VP_REQ;
                vram_sel_o  <= 1'b1;
                vram_wr_o   <= start_wr;
            end
        end
    end

    // request address and write word
    always_ff @(posedge clk) begin
        if (start_any) begin
            vram_addr_o <= req_addr;
            vram_data_o <= wr.word_data;    // ignored on reads
        end
    end

    assign regs.rd_incr = rd_incr;
    assign regs.rd_addr = rd_addr;
    assign regs.wr_incr = wr_incr;
    assign regs.wr_addr = wr_addr;
    assign regs.rd_data = rd_data;

endmodule

`default_nettype wire

// ==== logic/reg_write_merge.sv ====
// Host byte strobes to register events.
// Registers the strobes one cycle and assembles 16-bit words: the last even
// byte is kept with its register number and sits above the odd byte only
// when the odd byte goes to the same register.
`default_nettype none
`timescale 1ns/1ps

`include "xm_defs.svh"

module reg_write_merge (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   bus_wr_i,       // one-cycle write strobe
    input  wire logic                   bus_rd_i,       // one-cycle read strobe
    input  wire logic [3:0]             bus_reg_num_i,  // register number
    input  wire logic                   bus_bytesel_i,  // 0 even (high), 1 odd (low)
    input  wire logic [`XM_BYTE_W-1:0]  bus_data_i,     // write byte
    reg_wr_if.source                    wr              // merged events out
);

    xm_pkg::xm_reg_e        bus_reg;        // typed register number
    xm_pkg::xm_reg_e        held_reg;       // register of last even byte
    logic [`XM_BYTE_W-1:0]  held_byte;      // last even byte
    logic [`XM_BYTE_W-1:0]  even_part;      // upper half of assembled word

    assign bus_reg = xm_pkg::xm_reg_e'(bus_reg_num_i);

    // stale even byte from another register counts as zero
    assign even_part = (held_reg == bus_reg) ? held_byte : '0;

    // strobes and held even byte
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr.even_wr  <= 1'b0;
            wr.word_wr  <= 1'b0;
            wr.odd_rd   <= 1'b0;
            held_reg    <= xm_pkg::RD_INCR;
            held_byte   <= '0;              // odd-only write after reset sees zero
        end else begin
            wr.even_wr  <= bus_wr_i & ~bus_bytesel_i;
            wr.word_wr  <= bus_wr_i & bus_bytesel_i;
            wr.odd_rd   <= bus_rd_i & bus_bytesel_i;
            if (bus_wr_i && !bus_bytesel_i) begin
                held_reg    <= bus_reg;     // remember owner of even byte
                held_byte   <= bus_data_i;
            end
        end
    end

    // payload, valid alongside the strobes
    always_ff @(posedge clk) begin
        if (bus_wr_i || bus_rd_i) begin
            wr.reg_num      <= bus_reg;
            wr.byte_data    <= bus_data_i;
        end
        if (bus_wr_i && bus_bytesel_i) begin
            wr.word_data    <= {even_part, bus_data_i};   // word on odd byte
        end
    end

endmodule

`default_nettype wire

// ==== logic/vram_regs_if.sv ====
// VRAM port register values for host readback.
// Driven by vram_port, read by reg_read_mux.
`default_nettype none
`timescale 1ns/1ps

`include "xm_defs.svh"

interface vram_regs_if;

    logic [`XM_WORD_W-1:0]  rd_incr;    // read increment
    logic [`XM_WORD_W-1:0]  rd_addr;    // next read address
    logic [`XM_WORD_W-1:0]  wr_incr;    // write increment
    logic [`XM_WORD_W-1:0]  wr_addr;    // next write address
    logic [`XM_WORD_W-1:0]  rd_data;    // last word read from vram

    modport source (
        output rd_incr, rd_addr, wr_incr, wr_addr, rd_data
    );

    modport sink (
        input  rd_incr, rd_addr, wr_incr, wr_addr, rd_data
    );

endinterface

`default_nettype wire

// ==== logic/reg_wr_if.sv ====
// Host write/read events after byte merging.
// Driven by reg_write_merge, consumed by vram_port and sys_regs.
`default_nettype none
`timescale 1ns/1ps

`include "xm_defs.svh"

interface reg_wr_if;

    logic                   even_wr;    // even byte written
    logic                   word_wr;    // odd byte written, word complete
    logic                   odd_rd;     // odd byte read
    xm_pkg::xm_reg_e        reg_num;    // register addressed
    logic [`XM_BYTE_W-1:0]  byte_data;  // raw host byte
    logic [`XM_WORD_W-1:0]  word_data;  // held even byte above odd byte

    modport source (
        output even_wr, word_wr, odd_rd, reg_num, byte_data, word_data
    );

    modport sink (
        input  even_wr, word_wr, odd_rd, reg_num, byte_data, word_data
    );

endinterface

`default_nettype wire

// ==== logic/xm_pkg.sv ====
// Types shared by the register blocks.
// Referenced by scoped name, e.g. xm_pkg::DATA.
`default_nettype none

package xm_pkg;

    // host-visible register numbers, 8..15 unused
    typedef enum logic [3:0] {
        RD_INCR  = 4'd0,    // vram read increment
        RD_ADDR  = 4'd1,    // vram read address, write starts read
        WR_INCR  = 4'd2,    // vram write increment
        WR_ADDR  = 4'd3,    // vram write address
        DATA     = 4'd4,    // vram data port
        DATA_2   = 4'd5,    // alias of DATA
        SYS_CTRL = 4'd6,    // nibble write mask
        TIMER    = 4'd7     // 1/10 ms counter, read only
    } xm_reg_e;

    // vram request sequencer
    typedef enum logic [1:0] {
        VP_IDLE,            // no access pending
        VP_REQ,             // select held, waiting for free slot
        VP_ACK              // read done, data on bus this cycle
    } vram_state_e;

endpackage

`default_nettype wire

// ==== logic/xm_defs.svh ====
// Shared constants for the host register file.
// Include wherever clock rate, timer divider, widths or reset mask are needed.
`ifndef XM_DEFS_SVH
`define XM_DEFS_SVH

// pixel clock, drives the timer divider
`define XM_PCLK_HZ          25000000

// clocks per 1/10 ms timer tick
`define XM_TIMER_DIV        (`XM_PCLK_HZ / 10000)

// all four vram nibbles writable after reset
`define XM_WRMASK_RESET     4'b1111

// register word and host byte widths
`define XM_WORD_W           16
`define XM_BYTE_W           8

`endif
